// ==== Makefile ====
# Verilator build and run for the SCAD testbench

VERILATOR ?= verilator
TOP       ?= scadTb
FLIST     ?= tb.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert

SRCS := scadPkg.sv scadDecode.sv scadExecute.sv scadResult.sv \
        scadTop.sv scadAsserts.sv scadTb.sv
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)

# Pass or fail comes from the log
run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== scadAsserts.sv ====
/*
 * SCAD pipeline assertions
 * Strobe to result latency and output state during reset
 */
module scadAsserts (
   input logic            clk,
   input logic            rst,
   input logic            uopValid,
   input logic            resultValid,
   input scadPkg::scadOut result
);

   // Assertion failures so far
   int failCount = 0;

   //////////////////////////////
   // Handshake timing
   //////////////////////////////

   // Every strobe gives a result two cycles later
   strobeToResult: assert property (@(posedge clk) disable iff (rst)
      uopValid |-> ##2 resultValid)
      else
      begin
         $error("resultValid missing two cycles after uopValid");
         failCount++;
      end

   // No result pulse without its strobe
   resultHasStrobe: assert property (@(posedge clk) disable iff (rst)
      resultValid |-> $past(uopValid, 2))
      else
      begin
         $error("resultValid without a matching uopValid");
         failCount++;
      end

   //////////////////////////////
   // Reset state
   //////////////////////////////

   resetOutputs: assert property (@(posedge clk)
      rst |-> (!resultValid && result == '0))
      else
      begin
         $error("outputs not cleared during reset");
         failCount++;
      end

endmodule

bind scadTop scadAsserts u_scadAsserts (.*);

// ==== scadDecode.sv ====
/*
 * SCAD decode stage
 * Cuts the SCAD fields out of the control-ROM word and registers
 * them with the data-path word on each microinstruction strobe
 */
module scadDecode (
   input  logic             clk,
   input  logic             rst,
   input  logic             uopValid,
   input  scadPkg::cromWord crom,
   input  scadPkg::dataWord dp,
   output logic             decValid,
   output scadPkg::scadUop  decUop
);

   import scadPkg::*;

   //////////////////////////////
   // Field extraction
   //////////////////////////////

   scadUop uopNext;

   always_comb
   begin
      // Function and operand selects
      uopNext.fun    = scadFun'(crom[scadFunPos +: 3]);
      uopNext.asel   = scadAsel'(crom[scadAselPos +: 3]);
      uopNext.bsel   = scadBsel'(crom[scadBselPos +: 2]);
      // Small number, used as operand A or for byte framing
      uopNext.snum   = crom[snumPos +: 10];
      // Register load enables
      uopNext.loadSc = crom[loadScPos];
      uopNext.loadFe = crom[loadFePos];
      // Data path word rides along unchanged
      uopNext.data   = dp;
   end

   //////////////////////////////
   // Stage register
   //////////////////////////////

   // Valid follows the strobe by one cycle
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         decValid <= 1'b0;
      end
      else
      begin
         decValid <= uopValid;
      end
   end

   // Microword payload, holds between strobes
   always_ff @(posedge clk)
   begin
      if (uopValid)
      begin
         decUop <= uopNext;
      end
   end

endmodule

// ==== scadExecute.sv ====
/*
 * SCAD execute stage
 * Operand A and B muxes, the eight-function ALU, and the floating
 * exponent (FE) and step counter (SC) registers
 */
module scadExecute (
   input  logic             clk,
   input  logic             rst,
   input  logic             decValid,
   input  scadPkg::scadUop  decUop,
   output scadPkg::scadWord aluScad,
   output logic             aluValid,
   output scadPkg::scadWord feNext,
   output scadPkg::scadWord scNext
);

   import scadPkg::*;

   // Architectural registers
   scadWord fe;
   scadWord sc;

   // ALU operands
   scadWord opA;
   scadWord opB;

   //////////////////////////////
   // Operand A mux
   //////////////////////////////

   always_comb
   begin
      case (decUop.asel)
         aselSc:
            opA = sc;
         aselSnum:
            opA = decUop.snum;
         // Byte pointer position, octal 44 in the middle
         aselPtr44:
            opA = {sc[0], 6'o44, decUop.data[6], sc[8:9]};
         // Odd bytes framed by the small number
         aselByte1:
            opA = {decUop.snum[0], decUop.data[0:6], decUop.snum[8:9]};
         // Even bytes framed by SC
         aselByte2:
            opA = {sc[0], decUop.data[7:13], sc[8:9]};
         aselByte3:
            opA = {decUop.snum[0], decUop.data[14:20], decUop.snum[8:9]};
         aselByte4:
            opA = {sc[0], decUop.data[21:27], sc[8:9]};
         aselByte5:
            opA = {decUop.snum[0], decUop.data[28:34], decUop.snum[8:9]};
         default:
            opA = sc;
      endcase
   end

   //////////////////////////////
   // Operand B mux
   //////////////////////////////

   always_comb
   begin
      case (decUop.bsel)
         bselFe:
            opB = fe;
         // Exponent field, one's complement when the word is negative
         bselExp:
            if (decUop.data[0])
            begin
               opB = {2'b00, ~decUop.data[1:8]};
            end
            else
            begin
               opB = {2'b00, decUop.data[1:8]};
            end
         // Shift count, sign bit extended into the top two bits
         bselShift:
            opB = {decUop.data[18], decUop.data[18], decUop.data[28:35]};
         // Byte size, placed above three zero bits
         bselSize:
            opB = {1'b0, decUop.data[6:11], 3'b000};
         default:
            opB = fe;
      endcase
   end

   //////////////////////////////
   // ALU
   //////////////////////////////

   // All arithmetic wraps modulo 1024
   always_comb
   begin
      case (decUop.fun)
         funAPlusA:        aluScad = opA + opA;
         funAOrB:          aluScad = opA | opB;
         funAMinusBMinus1: aluScad = opA - opB - 10'd1;
         funAMinusB:       aluScad = opA - opB;
         funAPlusB:        aluScad = opA + opB;
         funAAndB:         aluScad = opA & opB;
         funAMinus1:       aluScad = opA - 10'd1;
         funA:             aluScad = opA;
         default:          aluScad = opA;
      endcase
   end

   // No extra latency through the ALU
   assign aluValid = decValid;

   //////////////////////////////
   // FE and SC registers
   //////////////////////////////

   // Values after the coming edge, also used for the result signs
   assign feNext = (decValid && decUop.loadFe) ? aluScad : fe;
   assign scNext = (decValid && decUop.loadSc) ? aluScad : sc;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         fe <= '0;
         sc <= '0;
      end
      else
      begin
         fe <= feNext;
         sc <= scNext;
      end
   end

endmodule

// ==== scadPkg.sv ====
/*
 * Step count adder shared definitions
 * Widths, control-ROM field positions, ALU and operand select codes,
 * and the structs carried between the pipeline stages
 */
package scadPkg;

   //////////////////////////////
   // Width types
   //////////////////////////////

   // Bit numbering is MSB first, bit 0 is the sign
   typedef logic [0:107] cromWord;
   typedef logic [0:35]  dataWord;
   typedef logic [0:9]   scadWord;
   typedef logic [0:9]   snumField;
   typedef logic [0:3]   dispCode;

   //////////////////////////////
   // Control-ROM field positions
   //////////////////////////////

   // First bit of each field within the microword
   localparam int scadFunPos  = 48;
   localparam int scadAselPos = 51;
   localparam int scadBselPos = 54;
   localparam int loadScPos   = 60;
   localparam int loadFePos   = 61;
   localparam int snumPos     = 98;

   // Dispatch code for a negative SCAD result
   localparam dispCode dispNegative = 4'b0010;

   //////////////////////////////
   // Select and function codes
   //////////////////////////////

   // ALU functions, order follows the microcode encoding
   typedef enum logic [2:0] {
      funAPlusA        = 3'd0,
      funAOrB          = 3'd1,
      funAMinusBMinus1 = 3'd2,
      funAMinusB       = 3'd3,
      funAPlusB        = 3'd4,
      funAAndB         = 3'd5,
      funAMinus1       = 3'd6,
      funA             = 3'd7
   } scadFun;

   // A operand sources
   typedef enum logic [2:0] {
      aselSc    = 3'd0,
      aselSnum  = 3'd1,
      aselPtr44 = 3'd2,
      aselByte1 = 3'd3,
      aselByte2 = 3'd4,
      aselByte3 = 3'd5,
      aselByte4 = 3'd6,
      aselByte5 = 3'd7
   } scadAsel;

   // B operand sources
   typedef enum logic [1:0] {
      bselFe    = 2'd0,
      bselExp   = 2'd1,
      bselShift = 2'd2,
      bselSize  = 2'd3
   } scadBsel;

   //////////////////////////////
   // Pipeline structs
   //////////////////////////////

   // Decoded microinstruction, 56 bits
   typedef struct packed {
      scadFun   fun;
      scadAsel  asel;
      scadBsel  bsel;
      snumField snum;
      logic     loadSc;
      logic     loadFe;
      dataWord  data;
   } scadUop;

   // Result seen by the microsequencer, 16 bits
   typedef struct packed {
      scadWord scad;
      logic    feSign;
      logic    scSign;
      dispCode disp;
   } scadOut;

endpackage

// ==== scadResult.sv ====
/*
 * SCAD result stage
 * Registers the SCAD value, FE and SC signs and the dispatch code
 */
module scadResult (
   input  logic             clk,
   input  logic             rst,
   input  logic             aluValid,
   input  scadPkg::scadWord aluScad,
   input  scadPkg::scadWord feNext,
   input  scadPkg::scadWord scNext,
   output logic             resultValid,
   output scadPkg::scadOut  result
);

   import scadPkg::*;

   scadOut resultNext;

   //////////////////////////////
   // Result assembly
   //////////////////////////////

   always_comb
   begin
      resultNext.scad   = aluScad;
      // Signs include this operation's own loads
      resultNext.feSign = feNext[0];
      resultNext.scSign = scNext[0];
      // Negative SCAD steers the microsequencer
      resultNext.disp   = aluScad[0] ? dispNegative : dispCode'(0);
   end

   //////////////////////////////
   // Output register
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         resultValid <= 1'b0;
         result      <= '0;
      end
      else
      begin
         // One-cycle pulse per ALU result
         resultValid <= aluValid;
         // Outputs hold between results
         if (aluValid)
         begin
            result <= resultNext;
         end
      end
   end

endmodule

// ==== scadTb.sv ====
/*
 * SCAD testbench
 * Seeded random microinstructions against an in-order model of FE, SC
 * and the result word, with a watchdog and a closing summary
 */
module scadTb;

   import scadPkg::*;

   //////////////////////////////
   // Run length
   //////////////////////////////

   localparam int numLoadOps     = 300;
   localparam int numDispOps     = 200;
   localparam int numMixedOps    = 2000;
   localparam int totalOps       = 1 + 18 + 50 + numLoadOps + numDispOps + numMixedOps;
   localparam int watchdogCycles = totalOps * 4 + 100;

   logic       clk = 1'b0;
   logic       rst;
   logic       uopValid;
   cromWord    crom;
   dataWord    dp;
   logic       resultValid;
   scadOut     result;

   // Model state and bookkeeping
   scadWord    feModel;
   scadWord    scModel;
   scadOut     expectQ[$];
   string      currentTest;
   int         errorCount;
   int         opCount;
   int         testCount;

   scadTop u_scadTop (
      .clk         (clk),
      .rst         (rst),
      .uopValid    (uopValid),
      .crom        (crom),
      .dp          (dp),
      .resultValid (resultValid),
      .result      (result)
   );

   // 40 unit period
   always #20 clk = ~clk;

   //////////////////////////////
   // Reference model
   //////////////////////////////

   function automatic scadWord operandA(scadAsel asel, snumField snum, dataWord data,
                                        scadWord scReg);
      scadWord val;
      scadWord frame;
      int      byteIdx;
      int      start;
      val = '0;
      if (asel == aselSc)
         val = scReg;
      else if (asel == aselSnum)
         val = snum;
      else if (asel == aselPtr44)
         val = {scReg[0], 6'o44, data[6], scReg[8:9]};
      else
      begin
         // Bytes 1..5 sit every 7 bits with odd ones framed by snum
         byteIdx = int'(asel) - int'(aselByte1);
         start   = 7 * byteIdx;
         frame   = (byteIdx % 2 == 0) ? snum : scReg;
         val[0]  = frame[0];
         for (int i = 0; i < 7; i++)
            val[1 + i] = data[start + i];
         val[8]  = frame[8];
         val[9]  = frame[9];
      end
      return val;
   endfunction

   function automatic scadWord operandB(scadBsel bsel, dataWord data, scadWord feReg);
      scadWord val;
      val = '0;
      case (bsel)
         bselFe:
            val = feReg;
         bselExp:
            // Exponent magnitude flipped for negative words
            for (int i = 1; i <= 8; i++)
               val[1 + i] = data[i] ^ data[0];
         bselShift:
         begin
            val[0] = data[18];
            val[1] = data[18];
            for (int i = 0; i < 8; i++)
               val[2 + i] = data[28 + i];
         end
         default:
            for (int i = 0; i < 6; i++)
               val[1 + i] = data[6 + i];
      endcase
      return val;
   endfunction

   function automatic scadWord aluModel(scadFun fun, scadWord a, scadWord b);
      int ia;
      int ib;
      int r;
      scadWord res;
      ia = int'(a);
      ib = int'(b);
      case (fun)
         funAPlusA:        r = ia + ia;
         funAOrB:          r = ia | ib;
         funAMinusBMinus1: r = ia - ib - 1;
         funAMinusB:       r = ia - ib;
         funAPlusB:        r = ia + ib;
         funAAndB:         r = ia & ib;
         funAMinus1:       r = ia - 1;
         default:          r = ia;
      endcase
      // Modulo 1024 even for negative differences
      r   = ((r % 1024) + 1024) % 1024;
      res = r[9:0];
      return res;
   endfunction

   //////////////////////////////
   // Check and stimulus tasks
   //////////////////////////////

   task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
         errorCount++;
      end
   endtask

   function automatic dataWord randData();
      logic [63:0] raw;
      raw = {$urandom(), $urandom()};
      return raw[35:0];
   endfunction

   function automatic snumField randSnum();
      return snumField'($urandom_range(0, 1023));
   endfunction

   function automatic logic randBit();
      return 1'($urandom_range(0, 1));
   endfunction

   // Drive one strobe, predict its result, return at the next falling edge
   task automatic sendOp(scadFun fun, scadAsel asel, scadBsel bsel, snumField snum,
                         logic loadSc, logic loadFe, dataWord data);
      logic [127:0] raw;
      scadWord      r;
      scadOut       expected;
      raw = {$urandom(), $urandom(), $urandom(), $urandom()};
      // Unused microword bits stay random
      crom = raw[107:0];
      crom[scadFunPos +: 3]  = fun;
      crom[scadAselPos +: 3] = asel;
      crom[scadBselPos +: 2] = bsel;
      crom[snumPos +: 10]    = snum;
      crom[loadScPos]        = loadSc;
      crom[loadFePos]        = loadFe;
      dp       = data;
      uopValid = 1'b1;
      r = aluModel(fun, operandA(asel, snum, data, scModel), operandB(bsel, data, feModel));
      if (loadSc)
         scModel = r;
      if (loadFe)
         feModel = r;
      expected.scad   = r;
      expected.feSign = feModel[0];
      expected.scSign = scModel[0];
      expected.disp   = r[0] ? dispNegative : 4'b0000;
      expectQ.push_back(expected);
      opCount++;
      @(negedge clk);
      uopValid = 1'b0;
   endtask

   task automatic sendRandomOp();
      sendOp(scadFun'(3'($urandom_range(0, 7))), scadAsel'(3'($urandom_range(0, 7))),
             scadBsel'(2'($urandom_range(0, 3))), randSnum(), randBit(), randBit(),
             randData());
   endtask

   // Let the pipeline empty, then report the test
   task automatic finishTest(int opsBefore, int errorsBefore);
      int waited;
      waited = 0;
      while (expectQ.size() != 0 && waited < 10)
      begin
         @(negedge clk);
         waited++;
      end
      if (expectQ.size() != 0)
      begin
         $display("Test %s ended with %0d results never delivered", currentTest,
                  expectQ.size());
         errorCount++;
         expectQ.delete();
      end
      testCount++;
      $display("Test %s done: %0d ops, %0d mismatches", currentTest,
               opCount - opsBefore, errorCount - errorsBefore);
   endtask

   //////////////////////////////
   // Result monitor
   //////////////////////////////

   // Registered outputs are settled at the falling edge
   always @(negedge clk)
   begin
      scadOut expected;
      if (resultValid)
      begin
         if (expectQ.size() == 0)
         begin
            $display("Test %s got a result with no operation outstanding", currentTest);
            errorCount++;
         end
         else
         begin
            expected = expectQ.pop_front();
            checkValue({currentTest, " scad"}, 32'(expected.scad), 32'(result.scad));
            checkValue({currentTest, " feSign"}, 32'(expected.feSign), 32'(result.feSign));
            checkValue({currentTest, " scSign"}, 32'(expected.scSign), 32'(result.scSign));
            checkValue({currentTest, " disp"}, 32'(expected.disp), 32'(result.disp));
         end
      end
   end

   // Watchdog
   initial
   begin
      repeat (watchdogCycles) @(posedge clk);
      $display("Timeout: run did not finish within %0d cycles", watchdogCycles);
      $display("CHECKS FAILED");
      $finish;
   end

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   initial
   begin
      scadWord feLoads[2];
      dataWord opData;
      int      ops0;
      int      err0;
      void'($urandom(32'h9e84b1ca));
      feLoads[0]  = 10'h0f3;
      feLoads[1]  = 10'h2a5;
      errorCount  = 0;
      opCount     = 0;
      testCount   = 0;
      feModel     = '0;
      scModel     = '0;
      currentTest = "reset";
      rst         = 1'b1;
      uopValid    = 1'b0;
      crom        = '0;
      dp          = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // Reset state
      currentTest = "resetState";
      ops0 = opCount;
      err0 = errorCount;
      repeat (5) @(negedge clk);
      checkValue("resetState valid", 32'd0, 32'(resultValid));
      checkValue("resetState result", 32'd0, 32'(result));
      sendOp(funA, aselSc, bselFe, randSnum(), 1'b0, 1'b0, randData());
      finishTest(ops0, err0);

      // All ALU functions with snum against a known FE
      currentTest = "aluFunctions";
      ops0 = opCount;
      err0 = errorCount;
      foreach (feLoads[k])
      begin
         sendOp(funA, aselSnum, bselFe, feLoads[k], 1'b0, 1'b1, randData());
         for (int f = 0; f < 8; f++)
            sendOp(scadFun'(3'(f)), aselSnum, bselFe, randSnum(), 1'b0, 1'b0, randData());
      end
      finishTest(ops0, err0);

      // Every A and B source after random SC and FE loads
      currentTest = "operandSelects";
      ops0 = opCount;
      err0 = errorCount;
      sendOp(funA, aselSnum, bselFe, randSnum(), 1'b1, 1'b0, randData());
      sendOp(funA, aselSnum, bselFe, randSnum(), 1'b0, 1'b1, randData());
      for (int a = 0; a < 8; a++)
         repeat (4)
            sendOp(funA, scadAsel'(3'(a)), scadBsel'(2'($urandom_range(0, 3))),
                   randSnum(), 1'b0, 1'b0, randData());
      // Zero small number passes B through the OR untouched
      for (int b = 0; b < 4; b++)
         for (int n = 0; n < 4; n++)
         begin
            opData    = randData();
            // Both exponent polarities
            opData[0] = n[0];
            sendOp(funAOrB, aselSnum, scadBsel'(2'(b)), '0, 1'b0, 1'b0, opData);
         end
      finishTest(ops0, err0);

      // Back-to-back loads with two ops in flight
      currentTest = "registerLoads";
      ops0 = opCount;
      err0 = errorCount;
      repeat (numLoadOps)
         sendRandomOp();
      finishTest(ops0, err0);

      // Random results for dispatch and signs
      currentTest = "dispatchSigns";
      ops0 = opCount;
      err0 = errorCount;
      repeat (numDispOps)
         sendOp(funA, aselSnum, bselFe, randSnum(), randBit(), randBit(), randData());
      finishTest(ops0, err0);

      // Fully random with idle gaps
      currentTest = "mixedRandom";
      ops0 = opCount;
      err0 = errorCount;
      repeat (numMixedOps)
      begin
         sendRandomOp();
         repeat ($urandom_range(0, 2)) @(negedge clk);
      end
      finishTest(ops0, err0);

      if (u_scadTop.u_scadAsserts.failCount != 0)
      begin
         $display("Pipeline checker reported %0d assertion failures",
                  u_scadTop.u_scadAsserts.failCount);
         errorCount += u_scadTop.u_scadAsserts.failCount;
      end

      $display("Summary: %0d tests, %0d operations, %0d errors", testCount, opCount,
               errorCount);
      if (errorCount == 0)
      begin
         $display("ALL CHECKS PASSED");
      end
      else
      begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// ==== scadTop.sv ====
/*
 * SCAD top level
 * Decode, execute and result stages in a two-cycle pipeline
 */
module scadTop (
   input  logic             clk,
   input  logic             rst,
   input  logic             uopValid,
   input  scadPkg::cromWord crom,
   input  scadPkg::dataWord dp,
   output logic             resultValid,
   output scadPkg::scadOut  result
);

   import scadPkg::*;

   // Decode to execute
   logic    decValid;
   scadUop  decUop;

   // Execute to result
   logic    aluValid;
   scadWord aluScad;
   scadWord feNext;
   scadWord scNext;

   scadDecode u_scadDecode (
      .clk      (clk),
      .rst      (rst),
      .uopValid (uopValid),
      .crom     (crom),
      .dp       (dp),
      .decValid (decValid),
      .decUop   (decUop)
   );

   scadExecute u_scadExecute (
      .clk      (clk),
      .rst      (rst),
      .decValid (decValid),
      .decUop   (decUop),
      .aluScad  (aluScad),
      .aluValid (aluValid),
      .feNext   (feNext),
      .scNext   (scNext)
   );

   scadResult u_scadResult (
      .clk         (clk),
      .rst         (rst),
      .aluValid    (aluValid),
      .aluScad     (aluScad),
      .feNext      (feNext),
      .scNext      (scNext),
      .resultValid (resultValid),
      .result      (result)
   );

endmodule

// ==== tb.f ====
scadPkg.sv
scadDecode.sv
scadExecute.sv
scadResult.sv
scadTop.sv
scadAsserts.sv
scadTb.sv
